//--- all.f
+incdir+source
source/afe_pkg.sv
source/adc_front.sv
source/dac_mixer.sv
source/moving_average.sv
source/dac_formatter.sv
source/analog_top.sv
tests/tb_clock.sv
tests/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and decides on the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_top -f all.f -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  || echo "Build or simulation ended with an error"

grep -qs "^TESTS PASSED$" sim.log && echo "Result: pass" && exit 0 \
  || { echo "Result: fail"; exit 1; }

//--- source/adc_front.sv
// ADC capture, negative slope to two's complement conversion and loopback select for analog_top
`include "afe_settings.svh"

module adc_front (
  input  logic              adc_clk,         // Sample clock
  input  logic              adc_rstn,        // Active low sync reset
  input  afe_pkg::adc_word_u adc_dat_a_i,    // Raw ADC word, channel A
  input  afe_pkg::adc_word_u adc_dat_b_i,    // Raw ADC word, channel B
  input  logic              digital_loop_i,  // Route DAC sums back to the inputs
  input  afe_pkg::sample_t  loop_a_i,        // Saturated DAC sum, channel A
  input  afe_pkg::sample_t  loop_b_i,        // Saturated DAC sum, channel B
  output afe_pkg::sample_t  adc_a_o,         // Conditioned sample, channel A
  output afe_pkg::sample_t  adc_b_o          // Conditioned sample, channel B
);

  // Bits below the sign, flipped by the conversion
  localparam logic [`AFE_SAMPLE_W-1:0] MAG_BITS = {1'b0, {(`AFE_SAMPLE_W-1){1'b1}}};

  // Keep sign and flip the magnitude bits
  function automatic afe_pkg::sample_t slope_conv(input afe_pkg::adc_word_u word);
    logic [`AFE_SAMPLE_W-1:0] dat;
    dat = word.field.data;  // Pad bits dropped here
    return {dat[`AFE_SAMPLE_W-1], ~dat[`AFE_SAMPLE_W-2:0]};
  endfunction

  ////////////////////////////////////////
  // Capture registers
  ////////////////////////////////////////

  afe_pkg::adc_word_u adc_a_q;  // Channel A as sampled
  afe_pkg::adc_word_u adc_b_q;  // Channel B as sampled

  // Meant for the IO block flops
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      adc_a_q <= '0;
      adc_b_q <= '0;
    end else begin
      adc_a_q <= adc_dat_a_i;
      adc_b_q <= adc_dat_b_i;
    end
  end

  ////////////////////////////////////////
  // Conversion and loopback
  ////////////////////////////////////////

  // Loopback bypasses the capture flops entirely
  assign adc_a_o = digital_loop_i ? loop_a_i : slope_conv(adc_a_q);
  assign adc_b_o = digital_loop_i ? loop_b_i : slope_conv(adc_b_q);

  // Unlooped output differs from the data field of the previous edge in the magnitude bits only
  a_capture_path : assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
    $past(adc_rstn) && !digital_loop_i |->
      ((adc_a_o ^ $past(adc_dat_a_i.field.data)) == MAG_BITS) &&
      ((adc_b_o ^ $past(adc_dat_b_i.field.data)) == MAG_BITS)
  );

endmodule

//--- source/afe_pkg.sv
// Sample, DAC code and ADC word types shared by the analog front end and its testbench
`include "afe_settings.svh"

package afe_pkg;

  ////////////////////////////////////////
  // Sample domain types
  ////////////////////////////////////////

  // Two's complement sample, instruments and mixer
  typedef logic signed [`AFE_SAMPLE_W-1:0] sample_t;

  // Unsigned code as the DAC sees it
  typedef logic [`AFE_SAMPLE_W-1:0] dac_code_t;

  ////////////////////////////////////////
  // ADC pin word
  ////////////////////////////////////////

  // Data field sits above the reserved pad
  typedef struct packed {
    logic [`AFE_SAMPLE_W-1:0]  data;  // Negative slope coded sample
    logic [`AFE_ADC_PAD_W-1:0] pad;   // Unused by a 14 bit converter
  } adc_field_t;

  // Same 16 bits, either raw or split
  typedef union packed {
    logic [`AFE_ADC_IN_W-1:0] raw;    // Whole word as sampled
    adc_field_t               field;  // Decoded view
  } adc_word_u;

endpackage

//--- source/afe_settings.svh
// Width and averaging depth defines for the analog front end, included by each file that sizes a signal
`ifndef AFE_SETTINGS_SVH
`define AFE_SETTINGS_SVH

////////////////////////////////////////
// ADC word layout
////////////////////////////////////////

// Raw word from the ADC pins
`define AFE_ADC_IN_W 16

// Reserved low bits of the raw word
`define AFE_ADC_PAD_W 2

// Signed sample and DAC code width
`define AFE_SAMPLE_W 14

////////////////////////////////////////
// Moving average on the DAC path
////////////////////////////////////////

`define AFE_AVG_LOG2 6   // 64 taps

// Running sum needs log2(depth) extra bits
`define AFE_AVG_SUM_W 20

`endif

//--- source/analog_top.sv
// Analog front end top, joining ADC conditioning, DAC mixing and DAC output formatting
`include "afe_settings.svh"

module analog_top (
  input  logic               adc_clk,         // Single clock for ADC and DAC
  input  logic               adc_rstn,        // Sync reset, active low
  // ADC pins
  input  afe_pkg::adc_word_u adc_dat_a_i,     // Raw word, channel A
  input  afe_pkg::adc_word_u adc_dat_b_i,     // Raw word, channel B
  // Configuration
  input  logic               digital_loop_i,  // DAC sums replace ADC samples
  // Instrument samples toward the DAC
  input  afe_pkg::sample_t   asg_a_i,
  input  afe_pkg::sample_t   asg_b_i,
  input  afe_pkg::sample_t   pid_a_i,
  input  afe_pkg::sample_t   pid_b_i,
  // Instrument samples from the ADC
  output afe_pkg::sample_t   adc_a_o,
  output afe_pkg::sample_t   adc_b_o,
  // DAC pins
  output afe_pkg::dac_code_t dac_dat_a_o,
  output afe_pkg::dac_code_t dac_dat_b_o
);

  afe_pkg::sample_t sum_a;  // Loopback only
  afe_pkg::sample_t sum_b;  // Loopback and DAC

  ////////////////////////////////////////
  // DAC side mix
  ////////////////////////////////////////

  dac_mixer u_mix (
    .adc_clk (adc_clk),
    .asg_a_i (asg_a_i),
    .asg_b_i (asg_b_i),
    .pid_a_i (pid_a_i),
    .pid_b_i (pid_b_i),
    .sum_a_o (sum_a),
    .sum_b_o (sum_b)
  );

  ////////////////////////////////////////
  // ADC side
  ////////////////////////////////////////

  adc_front u_adc (
    .adc_clk        (adc_clk),
    .adc_rstn       (adc_rstn),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop_i),
    .loop_a_i       (sum_a),
    .loop_b_i       (sum_b),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o)
  );

  // Both DAC words derive from channel B
  dac_formatter u_dac (
    .adc_clk     (adc_clk),
    .adc_rstn    (adc_rstn),
    .sum_b_i     (sum_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

//--- source/dac_formatter.sv
// Offset binary encoding of channel B and the registered DAC output words for both channels
`include "afe_settings.svh"

module dac_formatter (
  input  logic               adc_clk,      // Sample clock, DAC rate is the same
  input  logic               adc_rstn,     // Sync reset, active low
  input  afe_pkg::sample_t   sum_b_i,      // Saturated mix, channel B
  output afe_pkg::dac_code_t dac_dat_a_o,  // Averaged code, inverted
  output afe_pkg::dac_code_t dac_dat_b_o   // Direct code, channel B
);

  localparam int SW = `AFE_SAMPLE_W;

  ////////////////////////////////////////
  // Encoding
  ////////////////////////////////////////

  afe_pkg::dac_code_t        code_b;   // Offset binary, negative slope
  logic [`AFE_AVG_SUM_W-1:0] avg_sum;  // From the filter

  // Sign kept, magnitude flipped for the DAC slope
  assign code_b = {sum_b_i[SW-1], ~sum_b_i[SW-2:0]};

  moving_average u_avg (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .code_i   (code_b),
    .sum_o    (avg_sum)
  );

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  // Channel A gets the mean of channel B, top 14 bits divide by 64
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_dat_a_o <= '0;
      dac_dat_b_o <= '0;
    end else begin
      dac_dat_b_o <= code_b;
      dac_dat_a_o <= ~avg_sum[`AFE_AVG_SUM_W-1 -: SW];  // Two cycles behind sum_b_i
    end
  end

endmodule

//--- source/dac_mixer.sv
// Per channel sum of generator and PID samples, saturated to the DAC sample range
`include "afe_settings.svh"

module dac_mixer (
  input  logic             adc_clk,   // Only clocks the check below
  input  afe_pkg::sample_t asg_a_i,   // Generator, channel A
  input  afe_pkg::sample_t asg_b_i,   // Generator, channel B
  input  afe_pkg::sample_t pid_a_i,   // PID output, channel A
  input  afe_pkg::sample_t pid_b_i,   // PID output, channel B
  output afe_pkg::sample_t sum_a_o,   // Saturated sum, channel A
  output afe_pkg::sample_t sum_b_o    // Saturated sum, channel B
);

  localparam int SW = `AFE_SAMPLE_W;

  // Range ends of a sample
  localparam afe_pkg::sample_t SMP_MAX = {1'b0, {(SW-1){1'b1}}};  // +8191
  localparam afe_pkg::sample_t SMP_MIN = {1'b1, {(SW-1){1'b0}}};  // -8192

  // One extra bit holds any sum exactly
  typedef logic signed [SW:0] wide_t;

  // Top two bits differ on overflow, sign bit picks the rail
  function automatic afe_pkg::sample_t sat_add(input afe_pkg::sample_t a,
                                               input afe_pkg::sample_t b);
    wide_t s;
    s = wide_t'(a) + wide_t'(b);
    if (s[SW] ^ s[SW-1]) begin
      return {s[SW], {(SW-1){~s[SW]}}};
    end
    return s[SW-1:0];
  endfunction

  ////////////////////////////////////////
  // Mixing
  ////////////////////////////////////////

  assign sum_a_o = sat_add(asg_a_i, pid_a_i);  // Also feeds loopback only
  assign sum_b_o = sat_add(asg_b_i, pid_b_i);  // To DAC and loopback

  // A rail value needs same sign operands or an operand already on it
  a_rail_a : assert property (
    @(posedge adc_clk)
    (sum_a_o == SMP_MAX || sum_a_o == SMP_MIN) |->
      (asg_a_i[SW-1] == pid_a_i[SW-1]) || (asg_a_i == sum_a_o) || (pid_a_i == sum_a_o)
  );

  a_rail_b : assert property (
    @(posedge adc_clk)
    (sum_b_o == SMP_MAX || sum_b_o == SMP_MIN) |->
      (asg_b_i[SW-1] == pid_b_i[SW-1]) || (asg_b_i == sum_b_o) || (pid_b_i == sum_b_o)
  );

endmodule

//--- source/moving_average.sv
// Running sum over the last 64 DAC codes, kept in a ring buffer and updated every cycle
`include "afe_settings.svh"

module moving_average (
  input  logic                      adc_clk,   // Sample clock
  input  logic                      adc_rstn,  // Sync reset, active low
  input  afe_pkg::dac_code_t        code_i,    // New code each cycle
  output logic [`AFE_AVG_SUM_W-1:0] sum_o      // Sum of the last 64 codes
);

  localparam int unsigned DEPTH    = 1 << `AFE_AVG_LOG2;
  localparam int unsigned CODE_MAX = (1 << `AFE_SAMPLE_W) - 1;
  localparam int unsigned SUM_MAX  = DEPTH * CODE_MAX;  // Full history at top code

  ////////////////////////////////////////
  // History and running sum
  ////////////////////////////////////////

  afe_pkg::dac_code_t        hist_mem [DEPTH];  // Code history
  logic [`AFE_AVG_LOG2-1:0]  slot_q;            // Oldest entry, next to overwrite
  logic [`AFE_AVG_SUM_W-1:0] sum_q;             // Running total

  afe_pkg::dac_code_t        old_code;          // Code leaving the window
  logic [`AFE_AVG_SUM_W-1:0] sum_next;

  assign old_code = hist_mem[slot_q];

  // Add the newcomer, drop the code from 64 updates ago
  assign sum_next = sum_q + `AFE_AVG_SUM_W'(code_i) - `AFE_AVG_SUM_W'(old_code);

  // History cleared too, so the average restarts empty
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      slot_q <= '0;
      sum_q  <= '0;
      for (int k = 0; k < DEPTH; k++) begin
        hist_mem[k] <= '0;
      end
    end else begin
      hist_mem[slot_q] <= code_i;    // Replace oldest
      slot_q           <= slot_q + 1'b1;  // Wraps at 64 by width
      sum_q            <= sum_next;
    end
  end

  assign sum_o = sum_q;

  // Sum tracks the buffer contents, so it stays within 64 full scale codes
  a_sum_bound : assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
    sum_q <= SUM_MAX
  );

endmodule

//--- tests/tb_clock.sv
// Testbench clock and reset source, 20 unit period, 3 cycle power-up reset plus a requested reset
module tb_clock (
  input  logic rst_req_i,  // Extra reset from the test sequence
  output logic clk_o,      // To adc_clk
  output logic rstn_o      // To adc_rstn, active low
);

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 3;

  logic por_n;  // Power-up part

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Low through 3 rising edges, released on a falling edge
  initial begin
    por_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    por_n = 1'b1;
  end

  assign rstn_o = por_n & ~rst_req_i;

endmodule

//--- tests/tb_top.sv
// Self-checking testbench for analog_top, random stimulus against a cycle model, one line per test
`include "afe_settings.svh"

module tb_top;

  localparam int SW        = `AFE_SAMPLE_W;
  localparam int AVG_DEPTH = 1 << `AFE_AVG_LOG2;
  localparam int SMP_MAX   = (1 << (SW - 1)) - 1;  // +8191
  localparam int SMP_MIN   = -(1 << (SW - 1));     // -8192
  localparam logic [SW-1:0] MAG_MASK = {1'b0, {(SW-1){1'b1}}};  // Bits below the sign

  ////////////////////////////////////////
  // Cycle budget
  ////////////////////////////////////////

  localparam int N_CONV      = 200;
  localparam int N_LOOP      = 200;
  localparam int N_MIX       = 300;
  localparam int N_AVG_RAND  = 300;
  localparam int N_AVG_CONST = 70;
  localparam int N_RESTART   = 100;
  localparam int N_RESET     = 10;  // Both reset phases
  localparam int N_TOTAL     = N_CONV + N_LOOP + N_MIX + N_AVG_RAND
                               + N_AVG_CONST + N_RESTART + N_RESET;
  localparam int TIMEOUT     = (N_TOTAL + 100) * 20;

  logic               adc_clk;
  logic               adc_rstn;
  logic               rst_req;       // Mid-run reset
  afe_pkg::adc_word_u adc_dat_a;
  afe_pkg::adc_word_u adc_dat_b;
  logic               digital_loop;
  afe_pkg::sample_t   asg_a;
  afe_pkg::sample_t   asg_b;
  afe_pkg::sample_t   pid_a;
  afe_pkg::sample_t   pid_b;
  afe_pkg::sample_t   adc_a;
  afe_pkg::sample_t   adc_b;
  afe_pkg::dac_code_t dac_a;
  afe_pkg::dac_code_t dac_b;

  // Model state
  int hist [AVG_DEPTH];  // Code history
  int slot;
  int run_sum;
  int exp_cap_a;         // Converted captured words
  int exp_cap_b;
  int exp_dac_a;
  int exp_dac_b;

  logic [31:0] lcg_state;
  string       cur_test;
  int          err_total;
  int          test_errs;
  int          tests_ok;
  int          tests_bad;
  int          pos_sat;   // Channel B overflow counts
  int          neg_sat;

  tb_clock u_clk (
    .rst_req_i (rst_req),
    .clk_o     (adc_clk),
    .rstn_o    (adc_rstn)
  );

  analog_top DUT (
    .adc_clk        (adc_clk),
    .adc_rstn       (adc_rstn),
    .adc_dat_a_i    (adc_dat_a),
    .adc_dat_b_i    (adc_dat_b),
    .digital_loop_i (digital_loop),
    .asg_a_i        (asg_a),
    .asg_b_i        (asg_b),
    .pid_a_i        (pid_a),
    .pid_b_i        (pid_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b),
    .dac_dat_a_o    (dac_a),
    .dac_dat_b_o    (dac_b)
  );

  ////////////////////////////////////////
  // Stimulus and reference rules
  ////////////////////////////////////////

  // Upper half of the LCG state, low bits repeat too soon
  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // Rails mixed in at 3 of 8
  function automatic int rand_sample();
    logic [15:0]          pick;
    logic [15:0]          r;
    logic signed [SW-1:0] val;
    pick = next_rand();
    r    = next_rand();
    val  = r[SW-1:0];
    case (pick[15:13])
      3'd0:    return SMP_MAX;
      3'd1:    return -SMP_MAX;
      3'd2:    return SMP_MIN;
      default: return int'(val);
    endcase
  endfunction

  // Data field above the pad, sign kept, rest inverted
  function automatic int conv_adc(input logic [`AFE_ADC_IN_W-1:0] raw);
    logic [SW-1:0]        data;
    logic signed [SW-1:0] smp;
    data = raw[`AFE_ADC_IN_W-1 -: SW];
    smp  = data ^ MAG_MASK;
    return int'(smp);
  endfunction

  function automatic int sat_sum(input int a, input int b);
    int s;
    s = a + b;  // Exact sum
    if (s > SMP_MAX) return SMP_MAX;
    if (s < SMP_MIN) return SMP_MIN;
    return s;
  endfunction

  function automatic int encode(input int smp);
    logic [SW-1:0] c;
    c = smp[SW-1:0] ^ MAG_MASK;
    return int'(c);
  endfunction

  // Inverted top 14 bits of the running sum
  function automatic int avg_code(input int sum);
    logic [`AFE_AVG_SUM_W-1:0] s;
    logic [SW-1:0]             top;
    s   = sum[`AFE_AVG_SUM_W-1:0];
    top = ~s[`AFE_AVG_SUM_W-1 -: SW];
    return int'(top);
  endfunction

  // Registers of the DUT as seen by the model
  always @(posedge adc_clk) begin : model
    int code;
    if (!adc_rstn) begin
      slot      = 0;
      run_sum   = 0;
      exp_dac_a = 0;
      exp_dac_b = 0;
      exp_cap_a = conv_adc(16'h0000);  // Capture flops cleared
      exp_cap_b = conv_adc(16'h0000);
      for (int k = 0; k < AVG_DEPTH; k++) hist[k] = 0;
    end else begin
      code      = encode(sat_sum(int'(asg_b), int'(pid_b)));
      exp_dac_a = avg_code(run_sum);   // Sum from before this edge
      exp_dac_b = code;
      run_sum   = run_sum + code - hist[slot];
      hist[slot] = code;
      slot      = (slot + 1) % AVG_DEPTH;
      exp_cap_a = conv_adc(adc_dat_a.raw);
      exp_cap_b = conv_adc(adc_dat_b.raw);
    end
  end

  ////////////////////////////////////////
  // Checks and sequencing
  ////////////////////////////////////////

  task automatic compare(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("mismatch at time %0t: %s expected %0d, actual %0d", $time, name, exp, act);
      test_errs++;
      err_total++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      tests_ok++;
      $display("Test %s: ok", cur_test);
    end else begin
      tests_bad++;
      $display("Test %s: %0d errors", cur_test, test_errs);
    end
  endtask

  task automatic check_outputs();
    int exp_a;
    int exp_b;
    if (digital_loop) begin  // Same cycle as the inputs
      exp_a = sat_sum(int'(asg_a), int'(pid_a));
      exp_b = sat_sum(int'(asg_b), int'(pid_b));
    end else begin
      exp_a = exp_cap_a;
      exp_b = exp_cap_b;
    end
    compare("adc_a_o", exp_a, int'(adc_a));
    compare("adc_b_o", exp_b, int'(adc_b));
    compare("dac_dat_a_o", exp_dac_a, int'(dac_a));
    compare("dac_dat_b_o", exp_dac_b, int'(dac_b));
  endtask

  task automatic check_zero();
    compare("adc_a_o", 0, int'(adc_a));
    compare("adc_b_o", 0, int'(adc_b));
    compare("dac_dat_a_o", 0, int'(dac_a));
    compare("dac_dat_b_o", 0, int'(dac_b));
  endtask

  // Loopback of zero sums gives zero on the ADC side
  task automatic idle_inputs();
    adc_dat_a.raw = '0;
    adc_dat_b.raw = '0;
    digital_loop  = 1'b1;
    asg_a = '0;
    asg_b = '0;
    pid_a = '0;
    pid_b = '0;
  endtask

  task automatic drive_inputs(input logic loop, input bit hold_b, input int hold_val);
    int s;
    adc_dat_a.raw = next_rand();  // Pad bits random too
    adc_dat_b.raw = next_rand();
    digital_loop  = loop;
    asg_a = afe_pkg::sample_t'(rand_sample());
    pid_a = afe_pkg::sample_t'(rand_sample());
    if (hold_b) begin
      asg_b = afe_pkg::sample_t'(hold_val);
      pid_b = '0;
    end else begin
      asg_b = afe_pkg::sample_t'(rand_sample());
      pid_b = afe_pkg::sample_t'(rand_sample());
    end
    s = int'(asg_b) + int'(pid_b);
    if (s > SMP_MAX) pos_sat++;
    if (s < SMP_MIN) neg_sat++;
  endtask

  // Check what the last edge produced, then drive the next cycle
  task automatic run_cycles(input int n, input logic loop, input bit hold_b, input int hold_val);
    for (int i = 0; i < n; i++) begin
      @(negedge adc_clk);
      check_outputs();
      drive_inputs(loop, hold_b, hold_val);
    end
  endtask

  initial begin : watchdog
    #(TIMEOUT);
    $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : sequencer
    int            hold;
    logic [SW-1:0] inv;
    lcg_state = 32'd29;
    err_total = 0;
    tests_ok  = 0;
    tests_bad = 0;
    pos_sat   = 0;
    neg_sat   = 0;
    rst_req   = 1'b0;
    idle_inputs();

    start_test("power-up reset");
    repeat (2) @(negedge adc_clk);  // Two reset edges seen
    check_zero();
    end_test();
    @(posedge adc_rstn);

    start_test("adc conversion");
    run_cycles(N_CONV, 1'b0, 1'b0, 0);
    end_test();

    start_test("digital loopback");
    run_cycles(N_LOOP, 1'b1, 1'b0, 0);
    end_test();

    start_test("saturating mix");
    pos_sat = 0;
    neg_sat = 0;
    run_cycles(N_MIX, 1'b0, 1'b0, 0);
    if (pos_sat == 0 || neg_sat == 0) begin
      $display("Channel B sums did not overflow in both directions (up %0d, down %0d)",
               pos_sat, neg_sat);
      test_errs++;
      err_total++;
    end
    end_test();

    start_test("moving average");
    run_cycles(N_AVG_RAND, 1'b0, 1'b0, 0);
    hold = rand_sample();
    run_cycles(N_AVG_CONST, 1'b0, 1'b1, hold);
    inv = ~encode(hold) & 14'h3FFF;  // Full window of one code
    compare("dac_dat_a_o settled", int'(inv), int'(dac_a));
    end_test();

    start_test("mid-run reset");
    @(negedge adc_clk);
    check_outputs();
    rst_req = 1'b1;
    idle_inputs();
    repeat (3) @(negedge adc_clk);
    check_zero();
    rst_req = 1'b0;
    run_cycles(N_RESTART, 1'b0, 1'b0, 0);  // Model history empty again
    end_test();

    $display("Summary: %0d tests ok, %0d tests with errors, %0d errors in total",
             tests_ok, tests_bad, err_total);
    if (err_total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
